//--- Bender.yml
package:
  name: alu_pipe

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isa_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/fp_compare.sv
      - hdl/bit_count.sv
      - hdl/decode_stage.sv
      - hdl/exec_stage.sv
      - hdl/alu_pipe_top.sv
  - target: test
    files:
      - dv/alu_pipe_tb.sv

//--- dv/alu_pipe_tb.sv
module alu_pipe_tb
	import isa_pkg::*;
();

	// one table row: instruction, operands and the result it must give
	typedef struct packed {
		instr_t instr;
		value_t a;
		value_t b;
		value_t want;
	} row_s;

	logic   clk_i;
	logic   rst_i;
	logic   valid_i;
	instr_t instr_i;
	value_t a_i;
	value_t b_i;
	logic   valid_o;
	value_t result_o;

	row_s   rows[$];	// stimulus table
	value_t exp_q[$];	// results still owed by the DUT
	value_t last_res;	// result_o must hold this on bubbles
	logic [1:0] vexp;	// valid_i delayed by the two stages
	int     n_rows;
	int     n_checked;
	logic   table_ready;

	alu_pipe_top i_alu_pipe_top
	(
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.valid_i  (valid_i),
		.instr_i  (instr_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.valid_o  (valid_o),
		.result_o (result_o)
	);

	// ==========================================================
	// instruction encoding and reference arithmetic
	// ==========================================================
	function automatic instr_t major_instr(input logic [5:0] opc, input logic [15:0] imm);
		return {imm, 5'd0, 5'd0, opc};	// rd and ra unused here
	endfunction

	// fill lands in bit 31, the msb of shamt_fill
	function automatic instr_t r2_instr(input logic [5:0] fn, input logic [4:0] rb,
		input logic fill);
		return {fill, 4'd0, fn, rb, 5'd0, 5'd0, R2};
	endfunction

	function automatic instr_t unary_instr(input logic [4:0] sel);
		return r2_instr(R1, sel, 1'b0);	// selector rides in rb
	endfunction

	// integer results for the random rows
	function automatic value_t int_model(input func_e fn, input value_t a, input value_t b,
		input logic fill);
		int unsigned sh;
		value_t ones;
		sh   = b[4:0];
		ones = '1;
		case (fn)
		ADD:     return a + b;
		SUB:     return a - b;
		XOR:     return a ^ b;
		SLL:     return (a << sh) | (fill ? ~(ones << sh) : '0);	// fill enters low end
		SRL:     return (a >> sh) | (fill ? ~(ones >> sh) : '0);	// fill enters high end
		SRA:     return value_t'($signed(a) >>> sh);
		default: return '0;
		endcase
	endfunction

	task automatic add_row(input instr_t ins, input value_t a, input value_t b,
		input value_t want);
		rows.push_back(row_s'{instr: ins, a: a, b: b, want: want});
	endtask

	// ==========================================================
	// stimulus table
	// ==========================================================
	task automatic build_table();
		func_e  pick [6] = '{ADD, SUB, XOR, SLL, SRL, SRA};
		func_e  fn;
		value_t a, b;
		logic   fill;
		// integer arithmetic and logic, reg and imm forms
		add_row(r2_instr(ADD, 0, 0), 32'hffffffff, 32'h2, 32'h1);	// wraps
		add_row(r2_instr(SUB, 0, 0), 32'h5, 32'h7, 32'hfffffffe);
		add_row(major_instr(ADDI, 16'hfffe), 32'd10, 32'h0, 32'd8);	// imm is -2
		add_row(major_instr(SUBFI, 16'd100), 32'd30, 32'h0, 32'd70);	// imm - a
		add_row(major_instr(ANDI, 16'h00f0), 32'h123456ff, 32'h0, 32'hf0);
		add_row(major_instr(ORI, 16'h8000), 32'h1, 32'h0, 32'hffff8001);
		add_row(major_instr(XORI, 16'h00ff), 32'h0f0f0f0f, 32'h0, 32'h0f0f0ff0);
		add_row(r2_instr(AND, 0, 0), 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000);
		add_row(r2_instr(OR, 0, 0), 32'h0000ffff, 32'h00ff0000, 32'h00ffffff);
		add_row(r2_instr(XOR, 0, 0), 32'haaaaaaaa, 32'hffffffff, 32'h55555555);
		// shifts, fill clear and set
		add_row(r2_instr(SLL, 0, 0), 32'h1, 32'd4, 32'h10);
		add_row(r2_instr(SLL, 0, 1), 32'h1, 32'd4, 32'h1f);
		add_row(r2_instr(SRL, 0, 0), 32'h80000000, 32'd31, 32'h1);
		add_row(r2_instr(SRL, 0, 1), 32'h80000000, 32'd4, 32'hf8000000);
		add_row(r2_instr(SRA, 0, 0), 32'h80000000, 32'd4, 32'hf8000000);	// sign fill
		add_row(r2_instr(SRA, 0, 1), 32'h40000000, 32'd4, 32'h04000000);	// fill ignored
		add_row(r2_instr(SLLI, 8, 1), 32'hff, 32'hdeadbeef, 32'hffff);	// b unused
		add_row(r2_instr(SRLI, 16, 0), 32'h12345678, 32'hdeadbeef, 32'h1234);
		add_row(r2_instr(SRLI, 4, 1), 32'hf, 32'h0, 32'hf0000000);
		add_row(r2_instr(SRAI, 8, 0), 32'h80001234, 32'h0, 32'hff800012);
		// signed vs unsigned with a = -1, b = 1
		add_row(r2_instr(CMP_LT, 0, 0), 32'hffffffff, 32'h1, 32'h1);
		add_row(r2_instr(CMP_LTU, 0, 0), 32'hffffffff, 32'h1, 32'h0);
		add_row(r2_instr(CMP_GT, 0, 0), 32'hffffffff, 32'h1, 32'h0);
		add_row(r2_instr(CMP_GTU, 0, 0), 32'hffffffff, 32'h1, 32'h1);
		add_row(r2_instr(CMP_GE, 0, 0), 32'hffffffff, 32'h1, 32'h0);
		add_row(r2_instr(CMP_GEU, 0, 0), 32'hffffffff, 32'h1, 32'h1);
		add_row(r2_instr(CMP_LE, 0, 0), 32'hffffffff, 32'h1, 32'h1);
		add_row(r2_instr(CMP_LEU, 0, 0), 32'hffffffff, 32'h1, 32'h0);
		add_row(r2_instr(CMP_EQ, 0, 0), 32'h5, 32'h5, 32'h1);
		add_row(r2_instr(CMP_NE, 0, 0), 32'h5, 32'h5, 32'h0);
		add_row(major_instr(CMP_LTI, 16'hffff), 32'hfffffffe, 32'h0, 32'h1);
		add_row(major_instr(CMP_GEUI, 16'hffff), 32'h1, 32'h0, 32'h0);
		// combined vectors, a = -1 is also a float nan
		add_row(r2_instr(CMP, 0, 0), 32'hffffffff, 32'h1, 32'h01106106);
		add_row(major_instr(CMPI, 16'h0), 32'h3f800000, 32'h0, 32'h03e06700);	// 1.0 vs +0
		add_row(r2_instr(CMP, 0, 0), 32'h7fc00000, 32'h3f800000, 32'h01106700);	// qnan
		// float single compares
		add_row(r2_instr(FCMP_EQ, 0, 0), 32'h80000000, 32'h0, 32'h1);	// -0 == +0
		add_row(major_instr(FCMP_EQI, 16'h0), 32'h80000000, 32'h0, 32'h1);
		add_row(major_instr(FCMP_NEI, 16'h0), 32'h80000000, 32'h0, 32'h0);
		add_row(r2_instr(FCMP_LT, 0, 0), 32'h80000000, 32'h0, 32'h0);
		add_row(r2_instr(FCMP_NE, 0, 0), 32'h7fc00000, 32'h3f800000, 32'h1);	// unordered
		add_row(r2_instr(FCMP_EQ, 0, 0), 32'h7fc00000, 32'h7fc00000, 32'h0);
		add_row(r2_instr(FCMP_GE, 0, 0), 32'h7fc00000, 32'h3f800000, 32'h0);
		add_row(r2_instr(FCMP_LT, 0, 0), 32'hbf800000, 32'h3f800000, 32'h1);	// -1 < 1
		add_row(r2_instr(FCMP_LE, 0, 0), 32'hc0000000, 32'hbf800000, 32'h1);	// -2 <= -1
		add_row(major_instr(FCMP_GTI, 16'h3f80), 32'h40000000, 32'h0, 32'h1);
		// unary ops
		add_row(unary_instr(CNTLZ), 32'h0, 32'h0, 32'd32);
		add_row(unary_instr(CNTLZ), 32'h00010000, 32'h0, 32'd15);
		add_row(unary_instr(CNTPOP), 32'hf0f0000f, 32'h0, 32'd12);
		add_row(unary_instr(FABS), 32'hc0000000, 32'h0, 32'h40000000);
		add_row(unary_instr(FNABS), 32'h3f800000, 32'h0, 32'hbf800000);
		add_row(unary_instr(FNEG), 32'h3f800000, 32'h0, 32'hbf800000);
		add_row(unary_instr(FNEG), 32'h80000000, 32'h0, 32'h0);
		add_row(unary_instr(FSIGN), 32'hc0000000, 32'h0, 32'hbf800000);	// -2.0
		add_row(unary_instr(FSIGN), 32'h0, 32'h0, 32'h0);
		add_row(unary_instr(FSIGN), 32'h80000000, 32'h0, 32'h0);
		add_row(unary_instr(FSIGN), 32'h1, 32'h0, 32'h3f800000);	// tiny positive
		add_row(unary_instr(FFINITE), 32'h7f800000, 32'h0, 32'h0);	// +inf
		add_row(unary_instr(FFINITE), 32'h3f800000, 32'h0, 32'h1);
		add_row(unary_instr(FCLASS), 32'hff800000, 32'h0, 32'h80000003);	// -inf
		add_row(unary_instr(FCLASS), 32'h1, 32'h0, 32'h60);	// +subnormal
		add_row(unary_instr(FCLASS), 32'h7f800001, 32'h0, 32'h140);	// snan
		add_row(unary_instr(FCLASS), 32'h7fc00000, 32'h0, 32'h240);	// qnan
		// undefined encodings
		add_row(major_instr(6'h3f, 16'h1234), 32'h1234, 32'h5678, 32'h0);
		add_row(r2_instr(6'h3f, 0, 0), 32'h1234, 32'h5678, 32'h0);
		add_row(unary_instr(5'd31), 32'h1234, 32'h0, 32'h0);
		// random integer rows
		for (int i = 0; i < 18; i++)
		begin
			fn   = pick[i % 6];
			a    = $urandom;
			b    = $urandom;
			fill = 1'($urandom);
			add_row(r2_instr(fn, 0, fill), a, b, int_model(fn, a, b, fill));
		end
	endtask

	// ==========================================================
	// checks
	// ==========================================================
	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string sig, input value_t act, input value_t want);
		if (act !== want)
			fail_now($sformatf("Mismatch at %0t: %s expected %h, got %h",
				$time, sig, want, act));
	endtask

	task automatic check_valid(input logic act, input logic want);
		if (act !== want)
			fail_now($sformatf("Mismatch at %0t: valid_o expected %b, got %b",
				$time, want, act));
	endtask

	initial
	begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;	// period 8
	end

	// expected valid_o, one flop per stage
	always @(posedge clk_i)
	begin
		if (rst_i)
			vexp <= 2'b00;
		else
			vexp <= {vexp[0], valid_i};
	end

	// sample at the falling edge, away from the register updates
	always @(negedge clk_i)
	begin
		if (!rst_i)
		begin
			check_valid(valid_o, vexp[1]);
			if (vexp[1])
			begin
				if (exp_q.size() == 0)
					fail_now("a result arrived with no row pending");
				else
				begin
					last_res = exp_q.pop_front();
					check_value("result_o", result_o, last_res);
					n_checked++;
				end
			end
			else
				check_value("result_o", result_o, last_res);	// held on bubbles, 0 after reset
		end
	end

	initial
	begin
		wait (table_ready);
		#((n_rows + 10) * 8);
		fail_now("run timed out before every row produced a result");
	end

	// ==========================================================
	// main sequence
	// ==========================================================
	initial
	begin
		rst_i       = 1'b1;
		valid_i     = 1'b0;
		instr_i     = '0;
		a_i         = '0;
		b_i         = '0;
		last_res    = '0;
		n_checked   = 0;
		table_ready = 1'b0;
		void'($urandom(32'hceb5));
		build_table();
		n_rows      = rows.size();
		table_ready = 1'b1;
		repeat (2) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		foreach (rows[i])	// back to back, one row per cycle
		begin
			@(posedge clk_i);
			#1;
			valid_i = 1'b1;
			instr_i = rows[i].instr;
			a_i     = rows[i].a;
			b_i     = rows[i].b;
			exp_q.push_back(rows[i].want);
		end
		@(posedge clk_i);
		#1;
		valid_i = 1'b0;
		wait (n_checked == n_rows);
		repeat (5) @(posedge clk_i);	// four idle falling-edge checks, valid_o stays low
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- hdl/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// ==========================================================
// datapath widths shared by the packages and the RTL
// ==========================================================

`define VALUE_W 32	// one data word, also the single float width

`define SHAMT_W 5	// enough to shift across a full word

`define IMM_W 16	// immediate field of the major format

// the float decode in exec_stage and fp_compare
// assumes IEEE single layout inside VALUE_W

`endif

//--- hdl/alu_pipe_top.sv
module alu_pipe_top import isa_pkg::*, pipe_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   valid_i,	// one item per cycle, no stall
	input  instr_t instr_i,
	input  value_t a_i,
	input  value_t b_i,
	output logic   valid_o,	// 2 cycles after valid_i
	output value_t result_o
);

	dec_s dec;	// decode -> execute

	// ==========================================================
	// stage 1: decode
	// ==========================================================
	decode_stage i_decode_stage
	(
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.valid_i (valid_i),
		.instr_i (instr_i),
		.a_i     (a_i),
		.b_i     (b_i),
		.dec_o   (dec)
	);

	// ==========================================================
	// stage 2: execute
	// ==========================================================
	exec_stage i_exec_stage
	(
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.dec_i    (dec),
		.valid_o  (valid_o),
		.result_o (result_o)
	);

endmodule

//--- hdl/bit_count.sv
`include "alu_defs.svh"

module bit_count import isa_pkg::*;
(
	input  value_t     a_i,
	output logic [5:0] lz_o,	// leading zeros, 32 for a zero word
	output logic [5:0] pop_o	// number of set bits
);

	// ==========================================================
	// leading zero count
	// ==========================================================
	// scan upward, the last hit is the top set bit
	always_comb
	begin
		lz_o = 6'(`VALUE_W);
		for (int i = 0; i < `VALUE_W; i++)
		begin
			if (a_i[i])
				lz_o = 6'(`VALUE_W - 1 - i);
		end
	end

	// ==========================================================
	// population count
	// ==========================================================
	always_comb
	begin
		pop_o = '0;
		for (int i = 0; i < `VALUE_W; i++)
			pop_o = pop_o + 6'(a_i[i]);	// adder chain, fine at this width
	end

endmodule

//--- hdl/decode_stage.sv
`include "alu_defs.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   valid_i,
	input  instr_t instr_i,
	input  value_t a_i,
	input  value_t b_i,
	output dec_s   dec_o
);

	alu_op_e op_d;
	value_t  imm_sx;
	logic    imm_b;	// b comes from the immediate
	logic    valid_q;
	alu_op_e op_q;
	value_t  a_q, b_q;
	logic    fill_q;

	// low nibble of a compare encoding indexes the compare block of alu_op_e
	function automatic alu_op_e cmp_op(input logic [5:0] code);
		return alu_op_e'(int'(OP_CMP_EQ) + int'(code[3:0]));
	endfunction

	assign imm_sx = {{(`VALUE_W-`IMM_W){instr_i.any.imm[`IMM_W-1]}}, instr_i.any.imm};

	// ==========================================================
	// opcode / func / unary decode
	// ==========================================================
	always_comb
	begin
		op_d  = OP_NONE;
		imm_b = 1'b1;	// every major form except R2 uses the imm
		case (instr_i.any.opcode)
		R2:
		begin
			imm_b = 1'b0;
			case (instr_i.r2.func)
			R1:
				case (unary_e'(instr_i.r2.rb))
				CNTLZ:   op_d = OP_CNTLZ;
				CNTPOP:  op_d = OP_CNTPOP;
				FABS:    op_d = OP_FABS;
				FNABS:   op_d = OP_FNABS;
				FNEG:    op_d = OP_FNEG;
				FCLASS:  op_d = OP_FCLASS;
				FSIGN:   op_d = OP_FSIGN;
				FFINITE: op_d = OP_FFINITE;
				default: op_d = OP_NONE;
				endcase
			ADD:     op_d = OP_ADD;
			SUB:     op_d = OP_SUB;
			AND:     op_d = OP_AND;
			OR:      op_d = OP_OR;
			XOR:     op_d = OP_XOR;
			CMP:     op_d = OP_CMP;
			SLL:     op_d = OP_SLL;
			SRL:     op_d = OP_SRL;
			SRA:     op_d = OP_SRA;
			SLLI, SRLI, SRAI:
			begin
				// amount is imm[4:0], exec reads the low bits of b
				imm_b = 1'b1;
				op_d  = (instr_i.r2.func == SLLI) ? OP_SLL :
				        (instr_i.r2.func == SRLI) ? OP_SRL : OP_SRA;
			end
			default:
				if (instr_i.r2.func inside {[CMP_EQ:FCMP_GE]})
					op_d = cmp_op(instr_i.r2.func);
			endcase
		end
		ADDI:    op_d = OP_ADD;
		SUBFI:   op_d = OP_SUBF;
		ANDI:    op_d = OP_AND;
		ORI:     op_d = OP_OR;
		XORI:    op_d = OP_XOR;
		CMPI:    op_d = OP_CMP;
		default:
			if (instr_i.any.opcode inside {[CMP_EQI:FCMP_GEI]})
				op_d = cmp_op(instr_i.any.opcode);
		endcase
	end

	// ==========================================================
	// stage register
	// ==========================================================
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			valid_q <= 1'b0;
		else
			valid_q <= valid_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (valid_i)	// hold payload across bubbles
		begin
			op_q   <= op_d;
			a_q    <= a_i;
			b_q    <= imm_b ? imm_sx : b_i;
			fill_q <= instr_i.r2.shamt_fill[4];	// bit 31
		end
	end

	assign dec_o = '{valid: valid_q, op: op_q, a: a_q, b: b_q, fill: fill_q};

endmodule

//--- hdl/exec_stage.sv
`include "alu_defs.svh"

module exec_stage import isa_pkg::*, pipe_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_i,
	input  dec_s   dec_i,
	output logic   valid_o,
	output value_t result_o
);

	value_t a, b;
	shamt_t sh;
	fcmp_t  rel;	// float relations of a vs b
	logic [5:0] lz, pop;
	logic [2*`VALUE_W-1:0] sll_w, srl_w, sra_w;
	value_t cmp_vec, fclass, res;
	logic exp_ones, exp_zero, man_zero, is_zero, is_inf, is_nan;

	assign a  = dec_i.a;
	assign b  = dec_i.b;
	assign sh = dec_i.b[`SHAMT_W-1:0];

	fp_compare i_fp_compare
	(
		.a_i   (a),
		.b_i   (b),
		.rel_o (rel)
	);

	bit_count i_bit_count
	(
		.a_i   (a),
		.lz_o  (lz),
		.pop_o (pop)
	);

	// ==========================================================
	// shifter, double width so the fill bit shifts in
	// ==========================================================
	assign sll_w = {a, {`VALUE_W{dec_i.fill}}} << sh;	// result in upper half
	assign srl_w = {{`VALUE_W{dec_i.fill}}, a} >> sh;
	assign sra_w = {{`VALUE_W{a[`VALUE_W-1]}}, a} >> sh;	// sign fill

	// combined compare vector, integer low half, float upper
	always_comb
	begin
		cmp_vec        = '0;
		cmp_vec[0]     = a == b;
		cmp_vec[1]     = $signed(a) < $signed(b);
		cmp_vec[2]     = $signed(a) <= $signed(b);
		cmp_vec[5]     = a < b;	// unsigned
		cmp_vec[6]     = a <= b;
		cmp_vec[8]     = a != b;
		cmp_vec[9]     = $signed(a) >= $signed(b);
		cmp_vec[10]    = $signed(a) > $signed(b);
		cmp_vec[13]    = a >= b;
		cmp_vec[14]    = a > b;
		cmp_vec[20:16] = {rel.unord, rel.mag_lt, rel.le, rel.lt, rel.eq};
		cmp_vec[25:21] = {rel.ord, rel.mag_ge, rel.gt, rel.ge, rel.ne};
	end

	// single float classification of a
	assign exp_ones = &a[30:23];
	assign exp_zero = ~|a[30:23];
	assign man_zero = ~|a[22:0];
	assign is_zero  = exp_zero & man_zero;
	assign is_inf   = exp_ones & man_zero;
	assign is_nan   = exp_ones & ~man_zero;

	always_comb
	begin
		fclass     = '0;
		fclass[0]  = a[31] & is_inf;
		fclass[1]  = a[31];	// any negative
		fclass[2]  = a[31] & exp_zero & ~man_zero;	// subnormal
		fclass[3]  = a[31] & is_zero;
		fclass[4]  = ~a[31] & is_zero;
		fclass[5]  = ~a[31] & exp_zero & ~man_zero;
		fclass[6]  = ~a[31];
		fclass[7]  = ~a[31] & is_inf;
		fclass[8]  = is_nan & ~a[22];	// signalling, quiet bit clear
		fclass[9]  = is_nan & a[22];
		fclass[31] = a[31];
	end

	// ==========================================================
	// result mux
	// ==========================================================
	always_comb
	begin
		res = '0;	// OP_NONE and anything unknown
		case (dec_i.op)
		OP_ADD:      res = a + b;	// wraps
		OP_SUB:      res = a - b;
		OP_SUBF:     res = b - a;	// imm - a
		OP_AND:      res = a & b;
		OP_OR:       res = a | b;
		OP_XOR:      res = a ^ b;
		OP_SLL:      res = sll_w[2*`VALUE_W-1:`VALUE_W];
		OP_SRL:      res = srl_w[`VALUE_W-1:0];
		OP_SRA:      res = sra_w[`VALUE_W-1:0];
		OP_CMP:      res = cmp_vec;
		OP_CMP_EQ:   res = value_t'(cmp_vec[0]);
		OP_CMP_NE:   res = value_t'(cmp_vec[8]);
		OP_CMP_LT:   res = value_t'(cmp_vec[1]);
		OP_CMP_GE:   res = value_t'(cmp_vec[9]);
		OP_CMP_LE:   res = value_t'(cmp_vec[2]);
		OP_CMP_GT:   res = value_t'(cmp_vec[10]);
		OP_CMP_LTU:  res = value_t'(cmp_vec[5]);
		OP_CMP_GEU:  res = value_t'(cmp_vec[13]);
		OP_CMP_LEU:  res = value_t'(cmp_vec[6]);
		OP_CMP_GTU:  res = value_t'(cmp_vec[14]);
		OP_FCMP_EQ:  res = value_t'(rel.eq);
		OP_FCMP_NE:  res = value_t'(rel.ne | rel.unord);	// true for nan
		OP_FCMP_LT:  res = value_t'(rel.lt);
		OP_FCMP_LE:  res = value_t'(rel.le);
		OP_FCMP_GT:  res = value_t'(rel.gt);
		OP_FCMP_GE:  res = value_t'(rel.ge);
		OP_CNTLZ:    res = value_t'(lz);
		OP_CNTPOP:   res = value_t'(pop);
		OP_FABS:     res = {1'b0, a[30:0]};
		OP_FNABS:    res = {1'b1, a[30:0]};
		OP_FNEG:     res = {~a[31], a[30:0]};
		OP_FCLASS:   res = fclass;
		OP_FSIGN:    res = is_zero ? '0 : a[31] ? 32'hBF80_0000 : 32'h3F80_0000;
		OP_FFINITE:  res = {{(`VALUE_W-1){1'b0}}, ~exp_ones};
		default:     res = '0;
		endcase
	end

	// result register, holds its value on bubbles
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			valid_o  <= 1'b0;
			result_o <= '0;
		end
		else
		begin
			valid_o <= dec_i.valid;
			if (dec_i.valid)
				result_o <= res;
		end
	end

endmodule

//--- hdl/fp_compare.sv
`include "alu_defs.svh"

module fp_compare import isa_pkg::*, pipe_pkg::*;
(
	input  value_t a_i,
	input  value_t b_i,
	output fcmp_t  rel_o
);

	localparam int SB = `VALUE_W - 1;	// sign bit

	logic a_nan, b_nan;
	logic unord;
	logic both_zero;	// +0 and -0 together
	logic eq_raw, lt_raw;
	logic mag_lt;

	// nan: exponent all ones, mantissa nonzero
	assign a_nan = (&a_i[30:23]) & (|a_i[22:0]);
	assign b_nan = (&b_i[30:23]) & (|b_i[22:0]);
	assign unord = a_nan | b_nan;

	assign both_zero = ~|a_i[SB-1:0] & ~|b_i[SB-1:0];
	assign mag_lt    = a_i[SB-1:0] < b_i[SB-1:0];	// sign ignored
	assign eq_raw    = both_zero | (a_i == b_i);

	// sign-magnitude ordering
	always_comb
	begin
		if (both_zero)
			lt_raw = 1'b0;
		else if (a_i[SB] != b_i[SB])
			lt_raw = a_i[SB];	// negative side is smaller
		else if (a_i[SB])
			lt_raw = b_i[SB-1:0] < a_i[SB-1:0];	// both negative, larger mag is smaller
		else
			lt_raw = mag_lt;
	end

	// ==========================================================
	// relation vector, a nan kills every ordered relation
	// ==========================================================
	always_comb
	begin
		rel_o        = '0;
		rel_o.eq     = ~unord & eq_raw;
		rel_o.lt     = ~unord & lt_raw;
		rel_o.le     = ~unord & (lt_raw | eq_raw);
		rel_o.mag_lt = mag_lt;
		rel_o.unord  = unord;
		rel_o.rsv    = 3'b000;
		rel_o.ne     = ~unord & ~eq_raw;	// unordered is reported apart
		rel_o.ge     = ~unord & ~lt_raw;
		rel_o.gt     = ~unord & ~lt_raw & ~eq_raw;
		rel_o.mag_ge = ~mag_lt;
		rel_o.ord    = ~unord;
	end

endmodule

//--- hdl/isa_pkg.sv
`include "alu_defs.svh"

package isa_pkg;

	typedef logic [`VALUE_W-1:0] value_t;	// register operand / result word

	// ==========================================================
	// major opcodes, bits [5:0] of the instruction
	// ==========================================================
	// compare encodings keep their index in the low nibble
	typedef enum logic [5:0] {
		R2       = 6'h02,	// register form, func picks the op
		ADDI     = 6'h04,
		SUBFI    = 6'h05,	// imm - a
		ANDI     = 6'h08,
		ORI      = 6'h09,
		XORI     = 6'h0A,
		CMPI     = 6'h0B,	// full compare vector
		CMP_EQI  = 6'h10,
		CMP_NEI  = 6'h11,
		CMP_LTI  = 6'h12,
		CMP_GEI  = 6'h13,
		CMP_LEI  = 6'h14,
		CMP_GTI  = 6'h15,
		CMP_LTUI = 6'h16,
		CMP_GEUI = 6'h17,
		CMP_LEUI = 6'h18,
		CMP_GTUI = 6'h19,
		FCMP_EQI = 6'h1A,	// float compares follow the integer ones
		FCMP_NEI = 6'h1B,
		FCMP_LTI = 6'h1C,
		FCMP_LEI = 6'h1D,
		FCMP_GTI = 6'h1E,
		FCMP_GEI = 6'h1F
	} opcode_e;

	// R2 function field, same layout of the compare block as above
	typedef enum logic [5:0] {
		R1      = 6'h01,	// unary, selector sits in rb
		ADD     = 6'h04,
		SUB     = 6'h05,
		AND     = 6'h08,
		OR      = 6'h09,
		XOR     = 6'h0A,
		CMP     = 6'h0B,
		CMP_EQ  = 6'h10,
		CMP_NE  = 6'h11,
		CMP_LT  = 6'h12,
		CMP_GE  = 6'h13,
		CMP_LE  = 6'h14,
		CMP_GT  = 6'h15,
		CMP_LTU = 6'h16,
		CMP_GEU = 6'h17,
		CMP_LEU = 6'h18,
		CMP_GTU = 6'h19,
		FCMP_EQ = 6'h1A,
		FCMP_NE = 6'h1B,
		FCMP_LT = 6'h1C,
		FCMP_LE = 6'h1D,
		FCMP_GT = 6'h1E,
		FCMP_GE = 6'h1F,
		SLL     = 6'h20,	// shift by b
		SRL     = 6'h21,
		SRA     = 6'h22,
		SLLI    = 6'h24,	// shift by imm[4:0], i.e. the rb field
		SRLI    = 6'h25,
		SRAI    = 6'h26
	} func_e;

	typedef enum logic [4:0] {
		CNTLZ   = 5'd0,
		CNTPOP  = 5'd1,
		FABS    = 5'd4,
		FNABS   = 5'd5,
		FNEG    = 5'd6,
		FCLASS  = 5'd7,
		FSIGN   = 5'd8,
		FFINITE = 5'd9
	} unary_e;

	typedef struct packed {
		logic [`IMM_W-1:0] imm;	// [31:16]
		logic [4:0]        ra;
		logic [4:0]        rd;
		opcode_e           opcode;	// [5:0]
	} major_s;

	typedef struct packed {
		logic [4:0] shamt_fill;	// msb = bit 31 = shift fill bit
		func_e      func;
		logic [4:0] rb;	// register b, unary selector or shift amount
		logic [4:0] ra;
		logic [4:0] rd;
		opcode_e    opcode;
	} r2_s;

	typedef union packed {
		major_s any;	// view valid for every opcode
		r2_s    r2;	// view for opcode R2
	} instr_t;

endpackage

//--- hdl/pipe_pkg.sv
`include "alu_defs.svh"

package pipe_pkg;
	import isa_pkg::*;

	typedef logic [`SHAMT_W-1:0] shamt_t;	// shift distance

	// flat op list, reg and imm forms already merged by decode
	// the compare block must keep the order of the isa compare encodings
	typedef enum logic [5:0] {
		OP_NONE,
		OP_ADD, OP_SUB, OP_SUBF,
		OP_AND, OP_OR, OP_XOR,
		OP_SLL, OP_SRL, OP_SRA,
		OP_CMP,
		OP_CMP_EQ, OP_CMP_NE, OP_CMP_LT, OP_CMP_GE, OP_CMP_LE,
		OP_CMP_GT, OP_CMP_LTU, OP_CMP_GEU, OP_CMP_LEU, OP_CMP_GTU,
		OP_FCMP_EQ, OP_FCMP_NE, OP_FCMP_LT, OP_FCMP_LE, OP_FCMP_GT, OP_FCMP_GE,
		OP_CNTLZ, OP_CNTPOP,
		OP_FABS, OP_FNABS, OP_FNEG, OP_FCLASS, OP_FSIGN, OP_FFINITE
	} alu_op_e;

	typedef struct packed {
		logic    valid;
		alu_op_e op;
		value_t  a;
		value_t  b;	// register b or sign-extended imm
		logic    fill;	// shift fill bit from the instruction
	} dec_s;

	// float relation vector, bit 12 down to bit 0
	typedef struct packed {
		logic       ord;	// 12
		logic       mag_ge;
		logic       gt;
		logic       ge;
		logic       ne;	// 8, ordered and not equal
		logic [2:0] rsv;	// always zero
		logic       unord;	// 4
		logic       mag_lt;
		logic       le;
		logic       lt;
		logic       eq;	// 0
	} fcmp_t;

endpackage

//--- verilog.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fp_compare.sv
hdl/bit_count.sv
hdl/decode_stage.sv
hdl/exec_stage.sv
hdl/alu_pipe_top.sv
dv/alu_pipe_tb.sv
